// ==== source/umode_mon_pkg.sv ====
package umode_mon_pkg;

  // Privilege encodings as seen on the trace and on fetch prot[2:1]
  localparam logic [1:0] MODE_U = 2'b00;
  localparam logic [1:0] MODE_M = 2'b11;

  // Exception causes that mark a revoked instruction
  localparam logic [5:0] CAUSE_ACCESS_FAULT = 6'd1;
  localparam logic [5:0] CAUSE_BUS_FAULT    = 6'd24;

  localparam int unsigned NUM_EVENTS     = 8;
  localparam int unsigned EVENT_IDX_W    = 3;
  localparam int unsigned COUNT_W        = 16;
  localparam int unsigned REPORT_CREDITS = 2;
  localparam int unsigned CREDIT_W       = $clog2(REPORT_CREDITS + 1);

  localparam logic [6:0]  OPCODE_SYSTEM = 7'b1110011;
  localparam logic [31:0] MRET_INSN     = 32'h3020_0073;

  typedef struct packed {
    logic        valid;
    logic [31:0] insn;
    logic [31:0] pc;
    logic [31:0] rs1_rdata;
    logic [4:0]  rd_addr;
    logic [1:0]  mode;
    logic        dbg_mode;
    logic        trap;
    logic        exception;
    logic [5:0]  exception_cause;
  } retire_t;

  typedef struct packed {
    logic        req;
    logic        gnt;
    logic [31:0] addr;
    logic [2:0]  prot;
  } fetch_t;

  typedef enum logic [EVENT_IDX_W-1:0] {
    EV_URETIRE,
    EV_MRETIRE,
    EV_CSR_READ,
    EV_CSR_WRITE,
    EV_MRET,
    EV_UTRAP,
    EV_DMODE,
    EV_REFETCH
  } event_e;

  typedef logic [NUM_EVENTS-1:0] event_vec_t;

  typedef struct packed {
    logic [EVENT_IDX_W-1:0] idx;
    logic [COUNT_W-1:0]     count;
  } report_t;

endpackage

// ==== source/retire_classifier.sv ====
`timescale 1ns/1ps

module retire_classifier (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  umode_mon_pkg::retire_t    retire,
  output umode_mon_pkg::event_vec_t ret_events,
  output logic                      ret_pc_valid,
  output logic [31:0]               ret_pc
);
  import umode_mon_pkg::*;

  logic       revoked;
  logic       counted;
  logic [2:0] funct3;
  logic [4:0] rs1_field;
  logic       is_csr;
  logic       csrrw_like;
  logic [1:0] prev_mode_q;
  event_vec_t events_d;
  event_vec_t events_q;

  // Fetch faults retire as traps but never really executed
  assign revoked = retire.exception &&
                   (retire.exception_cause inside {CAUSE_ACCESS_FAULT, CAUSE_BUS_FAULT});
  assign counted = retire.valid && !revoked;

  assign funct3    = retire.insn[14:12];
  assign rs1_field = retire.insn[19:15];

  assign is_csr = counted && (retire.insn[6:0] == OPCODE_SYSTEM) &&
                  (funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});

  // csrrw and csrrwi always write and only read with a real rd
  assign csrrw_like = funct3 inside {3'd1, 3'd5};

  always_comb begin
    events_d = '0;
    if (counted) begin
      events_d[EV_URETIRE] = (retire.mode == MODE_U);
      events_d[EV_MRETIRE] = (retire.mode == MODE_M);
      events_d[EV_DMODE]   = retire.dbg_mode;
      events_d[EV_MRET]    = !retire.trap && (retire.insn == MRET_INSN);
      events_d[EV_UTRAP]   = retire.trap && (prev_mode_q == MODE_U);
    end
    events_d[EV_CSR_READ]  = is_csr && ((retire.rd_addr != 5'd0) || !csrrw_like);
    events_d[EV_CSR_WRITE] = is_csr && ((rs1_field != 5'd0) || csrrw_like);
  end

  // Mode of the last valid retirement, revoked ones included
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_mode_q <= MODE_M;
    end else if (retire.valid) begin
      prev_mode_q <= retire.mode;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      events_q <= '0;
    end else begin
      events_q <= events_d;
    end
  end

  assign ret_events = events_q;

  // Watcher registers its own hit, so the pc goes out undelayed
  assign ret_pc_valid = counted;
  assign ret_pc       = retire.pc;

endmodule

// ==== source/refetch_watch.sv ====
`timescale 1ns/1ps

module refetch_watch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  umode_mon_pkg::fetch_t fetch,
  input  logic                  ret_pc_valid,
  input  logic [31:0]           ret_pc,
  output logic                  refetch_hit
);
  import umode_mon_pkg::*;

  logic        aphase;
  logic        last_vld_q;
  logic [31:0] last_addr_q;
  logic [1:0]  last_prv_q;
  logic        arm;
  logic        armed_q;
  logic [31:0] armed_addr_q;
  logic        hit;

  assign aphase = fetch.req && fetch.gnt;

  // Same address granted twice in a row under another privilege
  assign arm = aphase && last_vld_q && (fetch.addr == last_addr_q) &&
               (fetch.prot[2:1] != last_prv_q);

  assign hit = armed_q && ret_pc_valid && (ret_pc == armed_addr_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_vld_q  <= 1'b0;
      armed_q     <= 1'b0;
      refetch_hit <= 1'b0;
    end else begin
      refetch_hit <= hit;
      if (aphase) last_vld_q <= 1'b1;
      if (hit) armed_q <= 1'b0;
      // New arming wins over a disarm in the same cycle
      if (arm) armed_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aphase) begin
      last_addr_q <= fetch.addr;
      last_prv_q  <= fetch.prot[2:1];
    end
    if (arm) armed_addr_q <= fetch.addr;
  end

endmodule

// ==== source/event_counter_bank.sv ====
`timescale 1ns/1ps

module event_counter_bank (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  umode_mon_pkg::event_vec_t              events,
  input  logic [umode_mon_pkg::EVENT_IDX_W-1:0]  rd_idx,
  output logic [umode_mon_pkg::COUNT_W-1:0]      rd_count
);
  import umode_mon_pkg::*;

  logic [COUNT_W-1:0] count_q [NUM_EVENTS];
  logic [NUM_EVENTS-1:0] at_max;

  always_comb begin
    for (int i = 0; i < NUM_EVENTS; i++) begin
      at_max[i] = &count_q[i];
    end
  end

  // Saturating hit counters, cleared only by reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_EVENTS; i++) begin
        count_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_EVENTS; i++) begin
        if (events[i] && !at_max[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  // Read port answers within the cycle
  assign rd_count = count_q[rd_idx];

endmodule

// ==== source/report_sender.sv ====
`timescale 1ns/1ps

module report_sender (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  dump_req,
  input  logic                                  report_credit,
  output logic [umode_mon_pkg::EVENT_IDX_W-1:0] rd_idx,
  input  logic [umode_mon_pkg::COUNT_W-1:0]     rd_count,
  output logic                                  report_valid,
  output umode_mon_pkg::report_t                report,
  output logic                                  dump_busy
);
  import umode_mon_pkg::*;

  localparam logic [EVENT_IDX_W-1:0] LAST_IDX = EVENT_IDX_W'(NUM_EVENTS - 1);

  logic                   busy_q;
  logic [EVENT_IDX_W-1:0] idx_q;
  logic [CREDIT_W-1:0]    credit_q;
  logic                   send;

  assign send = busy_q && (credit_q != '0);

  // Index walker, held in place while out of credits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (!busy_q) begin
      if (dump_req) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end
    end else if (send) begin
      if (idx_q == LAST_IDX) busy_q <= 1'b0;
      else idx_q <= idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CREDIT_W'(REPORT_CREDITS);
    end else if (send && !report_credit) begin
      credit_q <= credit_q - 1'b1;
    end else if (!send && report_credit) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  assign rd_idx       = idx_q;
  assign report_valid = send;
  assign report.idx   = idx_q;
  assign report.count = rd_count;
  assign dump_busy    = busy_q;

endmodule

// ==== source/umode_mon_top.sv ====
`timescale 1ns/1ps

module umode_mon_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  umode_mon_pkg::retire_t retire,
  input  umode_mon_pkg::fetch_t  fetch,
  input  logic                   dump_req,
  input  logic                   report_credit,
  output logic                   report_valid,
  output umode_mon_pkg::report_t report,
  output logic                   dump_busy
);
  import umode_mon_pkg::*;

  event_vec_t             ret_events;
  event_vec_t             bank_events;
  logic                   ret_pc_valid;
  logic [31:0]            ret_pc;
  logic                   refetch_hit;
  logic [EVENT_IDX_W-1:0] rd_idx;
  logic [COUNT_W-1:0]     rd_count;

  retire_classifier i_retire_classifier (
    .clk_i, .rst_ni, .retire, .ret_events, .ret_pc_valid, .ret_pc
  );

  refetch_watch i_refetch_watch (
    .clk_i, .rst_ni, .fetch, .ret_pc_valid, .ret_pc, .refetch_hit
  );

  // Refetch pulse lands in its own slot of the event vector
  always_comb begin
    bank_events             = ret_events;
    bank_events[EV_REFETCH] = refetch_hit;
  end

  event_counter_bank i_event_counter_bank (
    .clk_i, .rst_ni, .events(bank_events), .rd_idx, .rd_count
  );

  report_sender i_report_sender (
    .clk_i, .rst_ni, .dump_req, .report_credit, .rd_idx, .rd_count,
    .report_valid, .report, .dump_busy
  );

endmodule

// ==== verif/umode_mon_properties.sv ====
`timescale 1ns/1ps

module umode_mon_properties (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic                                report_valid,
  input logic                                report_credit,
  input logic                                dump_busy,
  input logic [umode_mon_pkg::CREDIT_W-1:0]  credit_q
);
  import umode_mon_pkg::*;

  int avail_q;

  // Credits left at the collector, seen from the channel alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      avail_q <= int'(REPORT_CREDITS);
    end else begin
      avail_q <= avail_q + int'(report_credit) - int'(report_valid);
    end
  end

  no_send_without_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    report_valid |-> avail_q > 0)
    else $error("report_valid high with zero credits");

  credit_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CREDIT_W'(REPORT_CREDITS))
    else $error("credit count above its initial value");

  idle_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !report_valid && !dump_busy)
    else $error("channel not idle during reset");

endmodule

bind report_sender umode_mon_properties i_umode_mon_properties (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .report_valid(report_valid),
  .report_credit(report_credit),
  .dump_busy(dump_busy),
  .credit_q(credit_q)
);

// ==== verif/umode_mon_checker.sv ====
`timescale 1ns/1ps

module umode_mon_checker (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    dump_req,
  input  logic                                                    report_valid,
  input  umode_mon_pkg::report_t                                  report,
  input  logic                                                    report_credit,
  input  logic                                                    dump_busy,
  input  logic [umode_mon_pkg::NUM_EVENTS-1:0][umode_mon_pkg::COUNT_W-1:0] exp_counts,
  output int unsigned                                             value_errors,
  output int unsigned                                             protocol_errors
);
  import umode_mon_pkg::*;

  logic [EVENT_IDX_W-1:0] next_idx = '0;
  int unsigned            seen = 0;
  int unsigned            sent_cnt = 0;
  int unsigned            returned_cnt = 0;
  logic                   busy_prev = 1'b0;
  logic                   req_q = 1'b0;

  initial begin
    value_errors    = 0;
    protocol_errors = 0;
  end

  // Sampled mid-cycle where the channel is stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (report_valid) begin
        sent_cnt++;
        if (seen >= NUM_EVENTS) begin
          $display("%0t: a record was sent after the last index", $time);
          protocol_errors++;
        end else begin
          if (report.idx != next_idx) begin
            $display("[ERROR] %0t report.idx expected %0d actual %0d",
                     $time, next_idx, report.idx);
            value_errors++;
          end
          if (report.count != exp_counts[next_idx]) begin
            $display("[ERROR] %0t report.count expected %0d actual %0d",
                     $time, exp_counts[next_idx], report.count);
            value_errors++;
          end
          next_idx++;
          seen++;
        end
        if (sent_cnt - returned_cnt > REPORT_CREDITS) begin
          $display("%0t: more records outstanding than the collector has credits", $time);
          protocol_errors++;
        end
      end
      if (req_q && !busy_prev && !dump_busy) begin
        $display("%0t: dump_busy did not rise after dump_req", $time);
        protocol_errors++;
      end
      if (busy_prev && !dump_busy && seen != NUM_EVENTS) begin
        $display("%0t: dump ended with only %0d of %0d records", $time, seen, NUM_EVENTS);
        protocol_errors++;
      end
      busy_prev = dump_busy;
    end
  end

  always @(posedge clk_i) begin
    if (report_credit) returned_cnt++;
    req_q = dump_req;
  end

endmodule

// ==== verif/umode_mon_tb.sv ====
`timescale 1ns/1ps

module umode_mon_tb;
  import umode_mon_pkg::*;

  localparam int HALF_PERIOD_NS = 50;

  localparam event_vec_t B_UR    = event_vec_t'(1 << EV_URETIRE);
  localparam event_vec_t B_MR    = event_vec_t'(1 << EV_MRETIRE);
  localparam event_vec_t B_CR    = event_vec_t'(1 << EV_CSR_READ);
  localparam event_vec_t B_CW    = event_vec_t'(1 << EV_CSR_WRITE);
  localparam event_vec_t B_MRET  = event_vec_t'(1 << EV_MRET);
  localparam event_vec_t B_UTRAP = event_vec_t'(1 << EV_UTRAP);
  localparam event_vec_t B_DM    = event_vec_t'(1 << EV_DMODE);
  localparam event_vec_t B_RF    = event_vec_t'(1 << EV_REFETCH);

  // Encodings of addi x1,x0,1 / ecall / csrrw x0,mscratch,x5 /
  // csrrs x6,mscratch,x0 / csrrc x7,mscratch,x8 / mret
  localparam logic [31:0] INSN_ADDI  = 32'h0010_0093;
  localparam logic [31:0] INSN_ECALL = 32'h0000_0073;
  localparam logic [31:0] INSN_CSRRW = 32'h3402_9073;
  localparam logic [31:0] INSN_CSRRS = 32'h3400_2373;
  localparam logic [31:0] INSN_CSRRC = 32'h3404_33f3;
  localparam logic [31:0] INSN_MRET  = 32'h3020_0073;

  typedef struct packed {
    retire_t    ret;
    fetch_t     fet;
    event_vec_t exp;
  } row_t;

  logic    clk_i;
  logic    rst_ni;
  retire_t retire;
  fetch_t  fetch;
  logic    dump_req;
  logic    report_credit;
  logic    report_valid;
  report_t report;
  logic    dump_busy;

  row_t                                 rows[$];
  logic [NUM_EVENTS-1:0][COUNT_W-1:0]   exp_counts;
  logic [31:0]                          lfsr_q = 32'hecf655bd;
  int unsigned                          value_errors;
  int unsigned                          protocol_errors;

  umode_mon_top i_umode_mon_top (
    .clk_i, .rst_ni, .retire, .fetch, .dump_req, .report_credit,
    .report_valid, .report, .dump_busy
  );

  umode_mon_checker i_umode_mon_checker (
    .clk_i, .rst_ni, .dump_req, .report_valid, .report, .report_credit, .dump_busy,
    .exp_counts, .value_errors, .protocol_errors
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD_NS clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic int unsigned rand_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_rand_bit());
    end
    return v;
  endfunction

  task automatic add_retire(input logic [31:0] insn, input logic [31:0] pc,
                            input logic [1:0] mode, input logic dbg, input logic trap,
                            input logic [5:0] cause, input event_vec_t exp);
    row_t r;
    r = '0;
    r.ret.valid           = 1'b1;
    r.ret.insn            = insn;
    r.ret.pc              = pc;
    r.ret.rd_addr         = insn[11:7];
    r.ret.mode            = mode;
    r.ret.dbg_mode        = dbg;
    r.ret.trap            = trap;
    r.ret.exception       = trap;
    r.ret.exception_cause = cause;
    r.exp                 = exp;
    rows.push_back(r);
  endtask

  task automatic add_fetch(input logic [31:0] addr, input logic [1:0] prv);
    row_t r;
    r = '0;
    r.fet.req  = 1'b1;
    r.fet.gnt  = 1'b1;
    r.fet.addr = addr;
    r.fet.prot = {prv, 1'b0};
    rows.push_back(r);
  endtask

  // Previous retired mode after reset is machine
  task automatic build_table();
    add_retire(INSN_ADDI, 32'h100, MODE_M, 1'b0, 1'b0, 6'd0, B_MR);
    add_retire(INSN_ADDI, 32'h104, MODE_U, 1'b0, 1'b0, 6'd0, B_UR);
    add_retire(INSN_ADDI, 32'h108, MODE_M, 1'b1, 1'b0, 6'd0, B_MR | B_DM);
    add_retire(INSN_ECALL, 32'h10c, MODE_U, 1'b0, 1'b1, 6'd8, B_UR);
    add_retire(INSN_ECALL, 32'h110, MODE_U, 1'b0, 1'b1, 6'd8, B_UR | B_UTRAP);
    // Revoked ones still move the previous mode
    add_retire(INSN_ADDI, 32'h114, MODE_U, 1'b0, 1'b1, CAUSE_ACCESS_FAULT, '0);
    add_retire(INSN_ADDI, 32'h118, MODE_M, 1'b0, 1'b1, CAUSE_BUS_FAULT, '0);
    add_retire(INSN_ECALL, 32'h11c, MODE_M, 1'b0, 1'b1, 6'd11, B_MR);
    add_retire(INSN_ADDI, 32'h120, MODE_U, 1'b0, 1'b0, 6'd0, B_UR);
    add_retire(INSN_ECALL, 32'h124, MODE_M, 1'b0, 1'b1, 6'd11, B_MR | B_UTRAP);
    add_retire(INSN_CSRRW, 32'h128, MODE_M, 1'b0, 1'b0, 6'd0, B_MR | B_CW);
    add_retire(INSN_CSRRS, 32'h12c, MODE_M, 1'b0, 1'b0, 6'd0, B_MR | B_CR);
    add_retire(INSN_CSRRC, 32'h130, MODE_M, 1'b0, 1'b0, 6'd0, B_MR | B_CR | B_CW);
    add_retire(INSN_ADDI, 32'h134, MODE_M, 1'b0, 1'b0, 6'd0, B_MR);
    add_retire(INSN_MRET, 32'h138, MODE_M, 1'b0, 1'b0, 6'd0, B_MR | B_MRET);
    add_retire(INSN_MRET, 32'h13c, MODE_M, 1'b0, 1'b1, 6'd2, B_MR);
    // Refetch under another privilege
    add_fetch(32'h2000, MODE_M);
    add_fetch(32'h2000, MODE_U);
    add_retire(INSN_ADDI, 32'h2000, MODE_U, 1'b0, 1'b0, 6'd0, B_UR | B_RF);
    // Same privilege twice
    add_fetch(32'h3000, MODE_M);
    add_fetch(32'h3000, MODE_M);
    add_retire(INSN_ADDI, 32'h3000, MODE_M, 1'b0, 1'b0, 6'd0, B_MR);
    // Different address
    add_fetch(32'h4000, MODE_M);
    add_fetch(32'h4004, MODE_U);
    add_retire(INSN_ADDI, 32'h4000, MODE_U, 1'b0, 1'b0, 6'd0, B_UR);
    add_retire(INSN_CSRRC, 32'h140, MODE_U, 1'b0, 1'b1, CAUSE_ACCESS_FAULT, '0);
  endtask

  initial begin
    retire     = '0;
    fetch      = '0;
    dump_req   = 1'b0;
    rst_ni     = 1'b0;
    exp_counts = '0;
    build_table();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (rows[i]) begin
      @(negedge clk_i);
      retire = rows[i].ret;
      fetch  = rows[i].fet;
      for (int e = 0; e < NUM_EVENTS; e++) begin
        if (rows[i].exp[e]) exp_counts[e] = exp_counts[e] + COUNT_W'(1);
      end
      @(negedge clk_i);
      retire = '0;
      fetch  = '0;
      repeat (rand_bits(2)) @(negedge clk_i);
    end

    // Let the last pulses reach the counters
    repeat (3) @(negedge clk_i);
    dump_req = 1'b1;
    @(negedge clk_i);
    dump_req = 1'b0;
    while (dump_busy) @(negedge clk_i);
    repeat (3) @(negedge clk_i);

    $display("Run complete: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Collector returns one credit per record after 0 to 3 cycles
  initial begin
    int unsigned cyc;
    int unsigned due_q[$];
    report_credit = 1'b0;
    cyc = 0;
    forever begin
      @(negedge clk_i);
      cyc++;
      report_credit = 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        report_credit = 1'b1;
      end
      if (report_valid) due_q.push_back(cyc + rand_bits(2));
    end
  end

  initial begin
    int unsigned limit;
    #1;
    limit = rows.size() * 5 + 100;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: dump did not complete within %0d cycles", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
source/umode_mon_pkg.sv
source/retire_classifier.sv
source/refetch_watch.sv
source/event_counter_bank.sv
source/report_sender.sv
source/umode_mon_top.sv
verif/umode_mon_properties.sv
verif/umode_mon_checker.sv
verif/umode_mon_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= umode_mon_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
